//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define CPU_XLEN 32

// general register count and the width of a register index
`define CPU_NREGS 8
`define CPU_RIDX 3

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- common/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // opcode zero is left unassigned so an all-zero word does nothing
    typedef enum logic [5:0] {
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        SHL   = 6'd6,
        SHR   = 6'd7,
        CMPEQ = 6'd8,
        CMPLT = 6'd9,
        LDI   = 6'd10,
        BRF   = 6'd11,
        JMP   = 6'd12,
        LD    = 6'd13,
        ST    = 6'd14,
        HALT  = 6'd15
    } opcode_t;

    typedef struct packed {
        logic [16:0] unused;
        logic [2:0]  rd;
        logic [2:0]  rb;
        logic [2:0]  ra;
        opcode_t     op;
    } instr_reg_t;

    // hi selects the upper half for LDI
    typedef struct packed {
        logic [15:0] imm;
        logic        hi;
        logic [2:0]  rd;
        logic [2:0]  rb;
        logic [2:0]  ra;
        opcode_t     op;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

endpackage

`default_nettype wire

//--- common/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_phase_t;

    // store is the only kind with bit 1 set, which marks a write
    typedef enum logic [1:0] {
        BUS_FETCH = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_kind_t;

endpackage

`default_nettype wire

//--- core/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`CPU_RIDX-1:0] ra,
    input  logic [`CPU_RIDX-1:0] rb,
    input  logic [`CPU_RIDX-1:0] rd,
    input  logic                 we,
    input  logic [`CPU_XLEN-1:0] wdata,
    input  logic                 fwe,
    input  logic                 fdata,
    output logic [`CPU_XLEN-1:0] rdata_a,
    output logic [`CPU_XLEN-1:0] rdata_b,
    output logic                 flag_a
);

    logic [`CPU_XLEN-1:0]  regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] flags;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
            flags <= '0;
        end
        else
        begin
            // register and flag are written independently
            if (we)
                regs[rd] <= wdata;
            if (fwe)
                flags[rd] <= fdata;
        end
    end

    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];
    assign flag_a  = flags[ra];

endmodule

`default_nettype wire

//--- core/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_alu import cpu_isa_pkg::*; (
    input  instr_t               instr,
    input  logic [`CPU_XLEN-1:0] op_a,
    input  logic [`CPU_XLEN-1:0] op_b,
    input  logic                 flag_a,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 res_flag,
    output logic                 we,
    output logic                 fwe,
    output logic                 take_jump
);

    localparam int SHW = $clog2(`CPU_XLEN);

    logic [SHW-1:0] shamt;
    logic           cmp_op;
    logic           cmp_flag;

    assign shamt = op_b[SHW-1:0];

    always_comb
    begin
        result   = '0;
        we       = 1'b0;
        fwe      = 1'b0;
        cmp_op   = 1'b0;
        cmp_flag = 1'b0;
        case (instr.r.op)
            ADD, SUB, AND, OR, XOR, SHL, SHR:
            begin
                we  = 1'b1;
                fwe = 1'b1;
                case (instr.r.op)
                    ADD:     result = op_a + op_b;
                    SUB:     result = op_a - op_b;
                    AND:     result = op_a & op_b;
                    OR:      result = op_a | op_b;
                    XOR:     result = op_a ^ op_b;
                    SHL:     result = op_a << shamt;
                    default: result = op_a >> shamt;
                endcase
            end
            CMPEQ:
            begin
                fwe      = 1'b1;
                cmp_op   = 1'b1;
                cmp_flag = (op_a == op_b);
            end
            CMPLT:
            begin
                fwe      = 1'b1;
                cmp_op   = 1'b1;
                cmp_flag = (op_a < op_b);
            end
            LDI:
            begin
                // op_b holds the old destination value, the other half is kept
                we = 1'b1;
                if (instr.i.hi)
                    result = {instr.i.imm, op_b[15:0]};
                else
                    result = {op_b[`CPU_XLEN-1:16], instr.i.imm};
            end
            default:
            begin
                we = 1'b0;
            end
        endcase
    end

    // zero flag for arithmetic, comparison outcome otherwise
    assign res_flag = cmp_op ? cmp_flag : (result == '0);

    assign take_jump = (instr.r.op == JMP) || ((instr.r.op == BRF) && flag_a);

endmodule

`default_nettype wire

//--- core/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_control import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output instr_t               instr,
    output logic                 req,
    output bus_kind_t            kind,
    output logic [`CPU_XLEN-1:0] addr,
    output logic [`CPU_XLEN-1:0] wdata,
    input  logic                 done,
    input  logic [`CPU_XLEN-1:0] rdata,
    output logic                 exec,
    input  logic                 take_jump,
    input  logic [`CPU_XLEN-1:0] store_data,
    input  logic [`CPU_XLEN-1:0] mem_addr,
    output logic                 load_we,
    output logic                 halted
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_t;

    localparam logic [`CPU_XLEN-1:0] WORD_BYTES = 4;

    state_t               state;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] next_pc;
    logic                 launch_fetch;
    logic                 is_mem_op;

    assign exec         = (state == S_EXEC);
    assign launch_fetch = (state == S_FETCH) && !req;
    assign is_mem_op    = (instr.r.op == LD) || (instr.r.op == ST);
    assign next_pc      = take_jump ? {{(`CPU_XLEN-16){1'b0}}, instr.i.imm} : pc + WORD_BYTES;
    assign load_we      = (state == S_MEM) && done && (kind == BUS_LOAD);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= S_FETCH;
            req    <= 1'b0;
            pc     <= `CPU_RESET_PC;
            halted <= 1'b0;
        end
        else
        begin
            case (state)
                S_FETCH:
                begin
                    if (done)
                    begin
                        req   <= 1'b0;
                        state <= S_EXEC;
                    end
                    else if (!req)
                        req <= 1'b1;
                end
                S_EXEC:
                begin
                    if (instr.r.op == HALT)
                    begin
                        halted <= 1'b1;
                        state  <= S_HALT;
                    end
                    else
                    begin
                        // next request goes out straight from execute
                        pc    <= next_pc;
                        req   <= 1'b1;
                        state <= is_mem_op ? S_MEM : S_FETCH;
                    end
                end
                S_MEM:
                begin
                    if (done)
                    begin
                        req   <= 1'b0;
                        state <= S_FETCH;
                    end
                end
                S_HALT:
                    state <= S_HALT;
                default:
                    state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == S_FETCH) && done)
            instr <= rdata;
        if (launch_fetch)
        begin
            kind <= BUS_FETCH;
            addr <= pc;
        end
        else if (exec)
        begin
            case (instr.r.op)
                LD:
                begin
                    kind <= BUS_LOAD;
                    addr <= mem_addr;
                end
                ST:
                begin
                    kind  <= BUS_STORE;
                    addr  <= mem_addr;
                    wdata <= store_data;
                end
                default:
                begin
                    kind <= BUS_FETCH;
                    addr <= next_pc;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/apb_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module apb_master import cpu_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  logic                 write,
    input  logic [`CPU_XLEN-1:0] addr,
    input  logic [`CPU_XLEN-1:0] wdata,
    output logic                 done,
    output logic [`CPU_XLEN-1:0] rdata,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output logic [`CPU_XLEN-1:0] paddr,
    output logic [`CPU_XLEN-1:0] pwdata,
    input  logic [`CPU_XLEN-1:0] prdata,
    input  logic                 pready
);

    apb_phase_t phase;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase  <= APB_IDLE;
            pwrite <= 1'b0;
        end
        else
        begin
            case (phase)
                APB_IDLE:
                begin
                    if (req)
                    begin
                        phase  <= APB_SETUP;
                        pwrite <= write;
                    end
                end
                APB_SETUP:
                    phase <= APB_ACCESS;
                APB_ACCESS:
                begin
                    // wait states just hold us here
                    if (pready)
                        phase <= APB_IDLE;
                end
                default:
                    phase <= APB_IDLE;
            endcase
        end
    end

    // address and write data stay put until the transfer ends
    always_ff @(posedge clk)
    begin
        if ((phase == APB_IDLE) && req)
        begin
            paddr  <= addr;
            pwdata <= wdata;
        end
    end

    assign psel    = (phase != APB_IDLE);
    assign penable = (phase == APB_ACCESS);
    assign done    = penable && pready;

    // requester takes the read word on the done edge
    assign rdata = prdata;

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_top import cpu_isa_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output logic [`CPU_XLEN-1:0] paddr,
    output logic [`CPU_XLEN-1:0] pwdata,
    input  logic [`CPU_XLEN-1:0] prdata,
    input  logic                 pready,
    output logic                 halted
);

    instr_t               instr;
    logic                 req;
    logic [1:0]           kind;
    logic [`CPU_XLEN-1:0] bus_addr;
    logic [`CPU_XLEN-1:0] bus_wdata;
    logic [`CPU_XLEN-1:0] bus_rdata;
    logic                 done;
    logic                 exec;
    logic                 load_we;
    logic [`CPU_XLEN-1:0] rdata_a;
    logic [`CPU_XLEN-1:0] rdata_b;
    logic                 flag_a;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 res_flag;
    logic                 alu_we;
    logic                 alu_fwe;
    logic                 take_jump;
    logic [`CPU_RIDX-1:0] rb_sel;
    logic [`CPU_XLEN-1:0] rf_wdata;
    logic                 rf_we;
    logic                 rf_fwe;

    // LDI merges into the destination, so read it on port b
    assign rb_sel   = (instr.r.op == LDI) ? instr.r.rd : instr.r.rb;
    assign rf_wdata = load_we ? bus_rdata : alu_result;
    assign rf_we    = load_we || (exec && alu_we);
    assign rf_fwe   = exec && alu_fwe;

    cpu_control i_control (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .req        (req),
        .kind       (kind),
        .addr       (bus_addr),
        .wdata      (bus_wdata),
        .done       (done),
        .rdata      (bus_rdata),
        .exec       (exec),
        .take_jump  (take_jump),
        .store_data (rdata_b),
        .mem_addr   (rdata_a),
        .load_we    (load_we),
        .halted     (halted)
    );

    cpu_regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra      (instr.r.ra),
        .rb      (rb_sel),
        .rd      (instr.r.rd),
        .we      (rf_we),
        .wdata   (rf_wdata),
        .fwe     (rf_fwe),
        .fdata   (res_flag),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .flag_a  (flag_a)
    );

    cpu_alu i_alu (
        .instr     (instr),
        .op_a      (rdata_a),
        .op_b      (rdata_b),
        .flag_a    (flag_a),
        .result    (alu_result),
        .res_flag  (res_flag),
        .we        (alu_we),
        .fwe       (alu_fwe),
        .take_jump (take_jump)
    );

    // bit 1 of the kind marks a store
    apb_master i_apb (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .write   (kind[1]),
        .addr    (bus_addr),
        .wdata   (bus_wdata),
        .done    (done),
        .rdata   (bus_rdata),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

`default_nettype wire

//--- sim/tb_cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_checker import cpu_isa_pkg::*; #(
    parameter int MEM_WORDS = 256,
    parameter int MAX_STEPS = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic        pready,
    input  logic        halted,
    input  logic [31:0] image [MEM_WORDS],
    input  logic        end_check,
    output int          value_errors,
    output int          other_errors,
    output logic        checks_done
);

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        exp_halt;
    int          store_idx;
    int          idle_edges;
    logic        first_seen;

    // instruction-set model run over the program image before the core starts
    function automatic void predict_stores();
        logic [31:0] m [MEM_WORDS];
        logic [31:0] r [8];
        logic [7:0]  f;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        instr_t      w;
        int          steps;
        for (int i = 0; i < MEM_WORDS; i++)
            m[i] = image[i];
        for (int i = 0; i < 8; i++)
            r[i] = '0;
        f        = '0;
        pc       = `CPU_RESET_PC;
        exp_halt = 1'b0;
        steps    = 0;
        while (!exp_halt && steps < MAX_STEPS)
        begin
            w       = m[(pc >> 2) % MEM_WORDS];
            a       = r[w.r.ra];
            b       = r[w.r.rb];
            pc_next = pc + 4;
            res     = '0;
            case (w.r.op)
                ADD, SUB, AND, OR, XOR, SHL, SHR:
                begin
                    case (w.r.op)
                        ADD:     res = a + b;
                        SUB:     res = a - b;
                        AND:     res = a & b;
                        OR:      res = a | b;
                        XOR:     res = a ^ b;
                        SHL:     res = a << b[4:0];
                        default: res = a >> b[4:0];
                    endcase
                    r[w.r.rd] = res;
                    f[w.r.rd] = (res == 0);
                end
                CMPEQ:
                    f[w.r.rd] = (a == b);
                CMPLT:
                    f[w.r.rd] = (a < b);
                LDI:
                begin
                    if (w.i.hi)
                        r[w.r.rd][31:16] = w.i.imm;
                    else
                        r[w.r.rd][15:0] = w.i.imm;
                end
                BRF:
                begin
                    if (f[w.r.ra])
                        pc_next = {16'h0000, w.i.imm};
                end
                JMP:
                    pc_next = {16'h0000, w.i.imm};
                LD:
                    r[w.r.rd] = m[(a >> 2) % MEM_WORDS];
                ST:
                begin
                    m[(a >> 2) % MEM_WORDS] = b;
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
                HALT:
                    exp_halt = 1'b1;
                default:
                    ;
            endcase
            pc = pc_next;
            steps++;
        end
    endfunction

    initial
    begin
        value_errors = 0;
        other_errors = 0;
        checks_done  = 1'b0;
        store_idx    = 0;
        idle_edges   = 0;
        first_seen   = 1'b0;
        @(posedge clk);
        predict_stores();
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (psel || penable || halted)
            begin
                $display("reset: bus select, enable or halted is high during reset");
                other_errors++;
            end
        end
        else
        begin
            if (!first_seen && !psel)
                idle_edges++;
            else if (!first_seen)
            begin
                first_seen = 1'b1;
                if (idle_edges > 2)
                begin
                    $display("reset: first fetch started %0d cycles after reset", idle_edges);
                    other_errors++;
                end
                if (pwrite)
                begin
                    $display("reset: first transfer is a write, not a fetch");
                    other_errors++;
                end
                if (paddr !== `CPU_RESET_PC)
                begin
                    $display("FAIL reset first fetch address: expected %h actual %h",
                             `CPU_RESET_PC, paddr);
                    value_errors++;
                end
            end

            if (halted && psel)
            begin
                $display("halt: bus transfer at %h after the core halted", paddr);
                other_errors++;
            end

            // a write completes on the access edge that sees pready
            if (psel && penable && pready && pwrite)
            begin
                if (store_idx >= exp_addr.size())
                begin
                    $display("store: unexpected extra store to %h", paddr);
                    other_errors++;
                end
                else
                begin
                    if (paddr !== exp_addr[store_idx])
                    begin
                        $display("FAIL store %0d address: expected %h actual %h",
                                 store_idx, exp_addr[store_idx], paddr);
                        value_errors++;
                    end
                    if (pwdata !== exp_data[store_idx])
                    begin
                        $display("FAIL store %0d data: expected %h actual %h",
                                 store_idx, exp_data[store_idx], pwdata);
                        value_errors++;
                    end
                end
                store_idx++;
            end

            if (end_check && !checks_done)
            begin
                if (store_idx != exp_addr.size())
                begin
                    $display("FAIL halt store count: expected %0d actual %0d",
                             exp_addr.size(), store_idx);
                    value_errors++;
                end
                if (halted !== exp_halt)
                begin
                    $display("FAIL halt final state: expected %0b actual %0b",
                             exp_halt, halted);
                    value_errors++;
                end
                checks_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_isa_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int N_PROG    = 38;
    // setup plus up to three wait states, the ready cycle and a gap
    localparam int WORST_XFER = 6;
    localparam int RESET_CYCLES = 10;
    localparam int TAIL_CYCLES = 20;
    localparam longint WATCHDOG_NS =
        (RESET_CYCLES + TAIL_CYCLES + N_PROG * WORST_XFER * 2) * 100;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        halted;
    logic [31:0] mem [MEM_WORDS];
    logic        end_check;
    int          value_errors;
    int          other_errors;
    logic        checks_done;
    int unsigned wait_left;

    cpu_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .halted  (halted)
    );

    tb_cpu_checker #(.MEM_WORDS(MEM_WORDS)) i_checker (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pready       (pready),
        .halted       (halted),
        .image        (mem),
        .end_check    (end_check),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .checks_done  (checks_done)
    );

    function automatic logic [31:0] encode_instr(opcode_t op, int ra, int rb, int rd,
                                                 logic hi, logic [15:0] imm);
        logic [2:0] a;
        logic [2:0] b;
        logic [2:0] d;
        a = ra[2:0];
        b = rb[2:0];
        d = rd[2:0];
        return {imm, hi, d, b, a, op};
    endfunction

    always #50 clk = ~clk;

    // APB memory with 0 to 3 wait states per transfer
    always @(posedge clk)
    begin
        #5;
        if (psel && !penable)
        begin
            wait_left = $urandom % 4;
            pready    = 1'b0;
        end
        else if (psel && penable && wait_left == 0)
        begin
            pready = 1'b1;
            prdata = mem[(paddr >> 2) % MEM_WORDS];
            if (pwrite)
                mem[(paddr >> 2) % MEM_WORDS] = pwdata;
        end
        else if (psel && penable)
        begin
            wait_left--;
            pready = 1'b0;
        end
        else
            pready = 1'b0;
    end

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        prdata    = '0;
        pready    = 1'b0;
        end_check = 1'b0;
        wait_left = 0;
        void'($urandom(32'h5c26));
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = i * 32'h9e37_79b9 + 32'h0bad_0000;
        // r1 store pointer, r5 step of one word
        mem[0]  = encode_instr(LDI, 0, 0, 1, 1'b0, 16'h0300);
        mem[1]  = encode_instr(LDI, 0, 0, 5, 1'b0, 16'h0004);
        mem[2]  = encode_instr(LDI, 0, 0, 2, 1'b0, 16'h5678);
        mem[3]  = encode_instr(LDI, 0, 0, 2, 1'b1, 16'h1234);
        mem[4]  = encode_instr(ST, 1, 2, 0, 1'b0, 16'h0);
        mem[5]  = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        mem[6]  = encode_instr(LDI, 0, 0, 3, 1'b0, 16'h00f0);
        mem[7]  = encode_instr(SUB, 2, 3, 4, 1'b0, 16'h0);
        mem[8]  = encode_instr(ST, 1, 4, 0, 1'b0, 16'h0);
        mem[9]  = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        mem[10] = encode_instr(AND, 2, 3, 4, 1'b0, 16'h0);
        mem[11] = encode_instr(ST, 1, 4, 0, 1'b0, 16'h0);
        mem[12] = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        // zero result sets the flag, so the branch skips word 15
        mem[13] = encode_instr(XOR, 2, 2, 4, 1'b0, 16'h0);
        mem[14] = encode_instr(BRF, 4, 0, 0, 1'b0, 16'h0040);
        mem[15] = encode_instr(ST, 1, 2, 0, 1'b0, 16'h0);
        mem[16] = encode_instr(OR, 2, 3, 4, 1'b0, 16'h0);
        mem[17] = encode_instr(BRF, 4, 0, 0, 1'b0, 16'h0050);
        mem[18] = encode_instr(SHL, 2, 5, 6, 1'b0, 16'h0);
        mem[19] = encode_instr(ST, 1, 6, 0, 1'b0, 16'h0);
        mem[20] = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        mem[21] = encode_instr(SHR, 2, 5, 6, 1'b0, 16'h0);
        mem[22] = encode_instr(ST, 1, 6, 0, 1'b0, 16'h0);
        mem[23] = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        mem[24] = encode_instr(CMPLT, 3, 2, 7, 1'b0, 16'h0);
        mem[25] = encode_instr(BRF, 7, 0, 0, 1'b0, 16'h006c);
        mem[26] = encode_instr(ST, 1, 3, 0, 1'b0, 16'h0);
        mem[27] = encode_instr(CMPEQ, 2, 3, 7, 1'b0, 16'h0);
        mem[28] = encode_instr(BRF, 7, 0, 0, 1'b0, 16'h0000);
        mem[29] = encode_instr(LDI, 0, 0, 6, 1'b0, 16'h0200);
        mem[30] = encode_instr(LD, 6, 0, 0, 1'b0, 16'h0);
        mem[31] = encode_instr(ST, 1, 0, 0, 1'b0, 16'h0);
        mem[32] = encode_instr(ADD, 1, 5, 1, 1'b0, 16'h0);
        mem[33] = encode_instr(JMP, 0, 0, 0, 1'b0, 16'h008c);
        mem[34] = encode_instr(ST, 1, 5, 0, 1'b0, 16'h0);
        mem[35] = encode_instr(ST, 1, 4, 0, 1'b0, 16'h0);
        mem[36] = encode_instr(HALT, 0, 0, 0, 1'b0, 16'h0);
        mem[37] = encode_instr(ST, 1, 2, 0, 1'b0, 16'h0);
        mem[128] = 32'hcafe_1234;

        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;

        wait (halted);
        // quiet window to catch any bus activity after halt
        repeat (TAIL_CYCLES) @(posedge clk);
        #5;
        end_check = 1'b1;
        wait (checks_done);
        #1;
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the core did not halt and finish its checks in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/cpu_isa_pkg.sv
common/cpu_bus_pkg.sv
core/cpu_regfile.sv
core/cpu_alu.sv
core/cpu_control.sv
verilog/apb_master.sv
verilog/cpu_top.sv
sim/tb_cpu_checker.sv
sim/tb_cpu_top.sv

//--- Makefile
# Verilator build and run for the APB register CPU

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
